// File: flist.f
+incdir+.
i3c_bus_pkg.sv
i3c_cfg_pkg.sv
i3c_phy_if.sv
bus_monitor.sv
configuration.sv
i2c_active_ctrl.sv
i2c_target_rx.sv
i3c_frontend.sv
tb_i3c_frontend.sv

// File: Bender.yml
package:
  name: i3c_frontend

sources:
  - include_dirs:
      - .
    files:
      - i3c_bus_pkg.sv
      - i3c_cfg_pkg.sv
      - i3c_phy_if.sv
      - bus_monitor.sv
      - configuration.sv
      - i2c_active_ctrl.sv
      - i2c_target_rx.sv
      - i3c_frontend.sv
      - target: test
        files:
          - tb_i3c_frontend.sv

// File: tb_i3c_frontend.sv
////////////////////////////////////////////////////////////////////////////
// Self-checking testbench for i3c_frontend with a wired-AND bus model
// The bench acts as I2C target in mode 0 and as I2C controller in mode 2
// Uses T_LOW = T_HIGH = 4 cycles for an 8-clock bit period
////////////////////////////////////////////////////////////////////////////

`include "i3c_macros.svh"

module tb_i3c_frontend;

  localparam int CLK_PERIOD  = 20;
  localparam int T_LOW       = 4;
  localparam int T_HIGH      = 4;
  localparam int BIT_CYCLES  = T_LOW + T_HIGH;
  localparam int NUM_ROWS    = 5;
  localparam int WATCHDOG_TIME = (NUM_ROWS * 12 + 40) * BIT_CYCLES * CLK_PERIOD;

  typedef struct packed {
    logic [1:0]               mode;
    logic [`I3C_ADDR_W-1:0]   static_addr;
    logic [`I3C_ADDR_W-1:0]   cmd_addr;
    logic                     rnw;
    logic [`I3C_ADDR_W-1:0]   resp_addr;
    logic                     exp_nack;
    logic [`I3C_ADDR_W:0]     exp_byte;
  } row_t;

  logic                       clk_i;
  logic                       arst_n_i;
  logic                       scl_o;
  logic                       sda_o;
  logic                       sel_od_pp_o;
  logic                       cfg_we_i;
  logic [`I3C_CFG_IDX_W-1:0]  cfg_idx_i;
  logic [`I3C_CFG_DATA_W-1:0] cfg_wdata_i;
  logic                       cmd_valid_i;
  logic [`I3C_ADDR_W-1:0]     cmd_addr_i;
  logic                       cmd_rnw_i;
  logic                       cmd_busy_o;
  logic                       cmd_done_o;
  logic                       cmd_nack_o;
  logic                       bus_start_o;
  logic                       bus_rstart_o;
  logic                       bus_stop_o;
  logic [`I3C_ADDR_W:0]       bus_addr_o;
  logic                       bus_addr_valid_o;

  // Bench drives on the open-drain bus
  logic                       tb_scl;
  logic                       tb_sda;
  logic                       tgt_ack_sda;
  logic                       scl_bus;
  logic                       sda_bus;

  row_t                       rows [NUM_ROWS];
  integer                     seed;
  int                         errors;
  int                         tests_run;
  int                         tests_failed;

  // Bench target model state
  logic                       target_en;
  logic [`I3C_ADDR_W-1:0]     resp_addr;
  logic [`I3C_ADDR_W:0]       tgt_byte;
  int                         tgt_bits;
  logic                       prev_scl;
  logic                       prev_sda;

  // Event record sampled on the falling clock edge
  int                         n_start;
  int                         n_rstart;
  int                         n_stop;
  int                         n_done;
  int                         n_addr_valid;
  time                        t_start;
  time                        t_stop;
  logic                       nack_at_done;
  logic                       busy_seen;
  logic                       pin_low_seen;
  logic                       pp_seen;
  logic [`I3C_ADDR_W:0]       last_addr;

  assign scl_bus = scl_o & tb_scl;
  assign sda_bus = sda_o & tb_sda & tgt_ack_sda;

  i3c_frontend DUT (
    .clk_i, .arst_n_i,
    .scl_i(scl_bus), .sda_i(sda_bus),
    .scl_o, .sda_o, .sel_od_pp_o,
    .cfg_we_i, .cfg_idx_i, .cfg_wdata_i,
    .cmd_valid_i, .cmd_addr_i, .cmd_rnw_i,
    .cmd_busy_o, .cmd_done_o, .cmd_nack_o,
    .bus_start_o, .bus_rstart_o, .bus_stop_o,
    .bus_addr_o, .bus_addr_valid_o
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("Run timed out at %0t before all tests finished", $time);
    $display("TB FAILED");
    $finish;
  end

  always @(negedge clk_i) begin
    if (arst_n_i) begin
      if (bus_start_o) begin
        if (n_start == 0) t_start = $time;
        n_start = n_start + 1;
      end
      if (bus_stop_o) begin
        if (n_stop == 0) t_stop = $time;
        n_stop = n_stop + 1;
      end
      if (bus_rstart_o) n_rstart = n_rstart + 1;
      if (cmd_done_o) begin
        n_done       = n_done + 1;
        nack_at_done = cmd_nack_o;
      end
      if (bus_addr_valid_o) begin
        n_addr_valid = n_addr_valid + 1;
        last_addr    = bus_addr_o;
      end
      if (cmd_busy_o) busy_seen = 1'b1;
      if (!scl_o || !sda_o) pin_low_seen = 1'b1;
      if (sel_od_pp_o) pp_seen = 1'b1;
    end
  end

  // Target model shifts the byte after START and ACKs a match in the ninth bit
  always @(posedge clk_i) begin
    #2;
    if (!target_en) begin
      tgt_ack_sda = 1'b1;
      tgt_bits    = 0;
    end else if (scl_bus && prev_scl && prev_sda && !sda_bus) begin
      tgt_bits = 0;
      tgt_byte = '0;
    end else if (scl_bus && !prev_scl) begin
      if (tgt_bits < 8) tgt_byte = {tgt_byte[`I3C_ADDR_W-1:0], sda_bus};
      tgt_bits = tgt_bits + 1;
    end else if (!scl_bus && prev_scl) begin
      tgt_ack_sda = (tgt_bits == 8) ? (tgt_byte[`I3C_ADDR_W:1] != resp_addr) : 1'b1;
    end
    prev_scl = scl_bus;
    prev_sda = sda_bus;
  end

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string msg);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s (got %0h, expected %0h)", $time, msg, got, exp);
      errors = errors + 1;
    end
  endtask

  task automatic step_cycles(input int n);
    repeat (n) @(posedge clk_i);
    #2;
  endtask

  function automatic row_t make_row(input logic [1:0] mode,
                                    input logic [`I3C_ADDR_W-1:0] static_addr,
                                    input logic [`I3C_ADDR_W-1:0] cmd_addr,
                                    input logic rnw,
                                    input logic [`I3C_ADDR_W-1:0] resp,
                                    input logic exp_nack);
    row_t r;
    r.mode        = mode;
    r.static_addr = static_addr;
    r.cmd_addr    = cmd_addr;
    r.rnw         = rnw;
    r.resp_addr   = resp;
    r.exp_nack    = exp_nack;
    // Address goes MSB first and RnW last
    r.exp_byte    = {cmd_addr, rnw};
    return r;
  endfunction

  function automatic logic [31:0] ctrl_word(input logic [1:0] mode,
                                            input logic [`I3C_ADDR_W-1:0] addr);
    logic [31:0] w;
    w       = '0;
    w[1:0]  = mode;
    w[8:2]  = addr;
    w[9]    = 1'b1;
    w[10]   = 1'b1;
    return w;
  endfunction

  task automatic build_table();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    a = $random(seed);
    b = $random(seed);
    c = $random(seed);
    d = $random(seed);
    rows[0] = make_row(2'd0, 7'h00, a[6:0], 1'b0, a[6:0], 1'b0);
    rows[1] = make_row(2'd0, 7'h00, b[6:0], 1'b1, b[6:0] ^ 7'h2a, 1'b1);
    rows[2] = make_row(2'd2, c[6:0], c[6:0], 1'b1, 7'h00, 1'b0);
    rows[3] = make_row(2'd2, d[6:0], d[6:0] ^ 7'h11, 1'b0, 7'h00, 1'b1);
    rows[4] = make_row(2'd1, 7'h00, a[6:0], 1'b0, 7'h00, 1'b1);
  endtask

  task automatic write_cfg(input logic [`I3C_CFG_IDX_W-1:0] idx,
                           input logic [`I3C_CFG_DATA_W-1:0] data);
    cfg_we_i    = 1'b1;
    cfg_idx_i   = idx;
    cfg_wdata_i = data;
    step_cycles(1);
    cfg_we_i    = 1'b0;
    step_cycles(1);
  endtask

  task automatic clear_record();
    n_start      = 0;
    n_rstart     = 0;
    n_stop       = 0;
    n_done       = 0;
    n_addr_valid = 0;
    t_start      = 0;
    t_stop       = 0;
    nack_at_done = 1'bx;
    busy_seen    = 1'b0;
    pin_low_seen = 1'b0;
    pp_seen      = 1'b0;
    last_addr    = 'x;
  endtask

  task automatic issue_cmd(input logic [`I3C_ADDR_W-1:0] addr, input logic rnw);
    cmd_valid_i = 1'b1;
    cmd_addr_i  = addr;
    cmd_rnw_i   = rnw;
    step_cycles(1);
    cmd_valid_i = 1'b0;
  endtask

  task automatic wait_done(input int limit);
    int n;
    n = 0;
    while (n_done == 0 && n < limit) begin
      @(posedge clk_i);
      n = n + 1;
    end
    #2;
    if (n_done == 0) begin
      $display("Command did not complete within %0d cycles at %0t", limit, $time);
      errors = errors + 1;
    end
  endtask

  // Bench as controller drives START, one byte, the ninth clock and STOP
  task automatic master_byte(input logic [`I3C_ADDR_W:0] value, output logic ninth_sda);
    tb_scl = 1'b1;
    tb_sda = 1'b1;
    step_cycles(T_HIGH);
    tb_sda = 1'b0;
    step_cycles(T_HIGH);
    for (int i = 0; i < 9; i++) begin
      tb_scl = 1'b0;
      tb_sda = (i < 8) ? value[7 - i] : 1'b1;
      step_cycles(T_LOW);
      tb_scl = 1'b1;
      step_cycles(T_HIGH / 2);
      if (i == 8) ninth_sda = sda_o;
      step_cycles(T_HIGH - T_HIGH / 2);
    end
    tb_scl = 1'b0;
    tb_sda = 1'b0;
    step_cycles(T_LOW);
    tb_scl = 1'b1;
    step_cycles(T_HIGH);
    tb_sda = 1'b1;
    step_cycles(T_HIGH);
  endtask

  task automatic run_row(input int r);
    int   errs_before;
    logic ninth_sda;
    errs_before = errors;
    write_cfg(i3c_cfg_pkg::idx_ctrl, ctrl_word(rows[r].mode, rows[r].static_addr));
    clear_record();
    case (rows[r].mode)
      2'd0: begin
        resp_addr = rows[r].resp_addr;
        target_en = 1'b1;
        issue_cmd(rows[r].cmd_addr, rows[r].rnw);
        wait_done(14 * BIT_CYCLES);
        step_cycles(T_LOW);
        target_en = 1'b0;
        check_value(n_start, 1, "one START on the bus");
        check_value(n_stop, 1, "one STOP on the bus");
        check_value(t_start < t_stop, 1, "START reported before STOP");
        check_value(n_rstart, 0, "no repeated START");
        check_value(busy_seen, 1, "busy during the command");
        check_value(n_done, 1, "one done pulse");
        check_value(nack_at_done, rows[r].exp_nack, "NACK flag at done");
        check_value(tgt_byte, rows[r].exp_byte, "address byte seen by the bench");
      end
      2'd2: begin
        master_byte(rows[r].exp_byte, ninth_sda);
        step_cycles(T_LOW);
        check_value(n_start, 1, "one START on the bus");
        check_value(n_stop, 1, "one STOP on the bus");
        check_value(n_addr_valid, 1, "one address report");
        check_value(last_addr, rows[r].exp_byte, "reported address byte");
        check_value(ninth_sda, rows[r].exp_nack, "DUT SDA in the ninth bit");
        check_value(pin_low_seen, !rows[r].exp_nack, "DUT pulls SDA only for an ACK");
      end
      default: begin
        issue_cmd(rows[r].cmd_addr, rows[r].rnw);
        step_cycles(12 * BIT_CYCLES);
        check_value(busy_seen, 0, "no busy for an ignored command");
        check_value(n_done, 0, "no done for an ignored command");
        check_value(pin_low_seen, 0, "pins stay released");
      end
    endcase
    check_value(pp_seen, 0, "open-drain select stays low");
    tests_run = tests_run + 1;
    if (errors != errs_before) tests_failed = tests_failed + 1;
    $display("test %0d mode %0d: %s", r, rows[r].mode,
             (errors == errs_before) ? "ok" : "errors");
  endtask

  initial begin
    arst_n_i    = 1'b0;
    cfg_we_i    = 1'b0;
    cfg_idx_i   = '0;
    cfg_wdata_i = '0;
    cmd_valid_i = 1'b0;
    cmd_addr_i  = '0;
    cmd_rnw_i   = 1'b0;
    tb_scl      = 1'b1;
    tb_sda      = 1'b1;
    tgt_ack_sda = 1'b1;
    target_en   = 1'b0;
    resp_addr   = '0;
    tgt_byte    = '0;
    tgt_bits    = 0;
    prev_scl    = 1'b1;
    prev_sda    = 1'b1;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    seed         = 32'h47656477;
    clear_record();
    build_table();
    repeat (2) @(posedge clk_i);
    #2;
    arst_n_i = 1'b1;
    @(negedge clk_i);
    check_value({scl_o, sda_o}, 2'b11, "pins released after reset");
    check_value(sel_od_pp_o, 0, "open-drain select after reset");
    check_value({cmd_busy_o, cmd_done_o, bus_start_o, bus_rstart_o, bus_stop_o,
                 bus_addr_valid_o}, 0, "busy and pulses low after reset");
    tests_run = tests_run + 1;
    if (errors != 0) tests_failed = tests_failed + 1;
    $display("test reset: %s", (errors == 0) ? "ok" : "errors");
    step_cycles(1);
    write_cfg(i3c_cfg_pkg::idx_t_low, T_LOW);
    write_cfg(i3c_cfg_pkg::idx_t_high, T_HIGH);
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: i3c_frontend.sv
////////////////////////////////////////////////////////////////////////////
// I2C front end: bus monitor, settings, active controller and standby target
// The mux code picks the peer on the pins; codes 1 and 3 leave the bus idle
// Pin outputs are open drain, 1 releases the line
////////////////////////////////////////////////////////////////////////////

`include "i3c_macros.svh"

module i3c_frontend (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       scl_i,
  input  logic                       sda_i,
  output logic                       scl_o,
  output logic                       sda_o,
  output logic                       sel_od_pp_o,
  input  logic                       cfg_we_i,
  input  logic [`I3C_CFG_IDX_W-1:0]  cfg_idx_i,
  input  logic [`I3C_CFG_DATA_W-1:0] cfg_wdata_i,
  input  logic                       cmd_valid_i,
  input  logic [`I3C_ADDR_W-1:0]     cmd_addr_i,
  input  logic                       cmd_rnw_i,
  output logic                       cmd_busy_o,
  output logic                       cmd_done_o,
  output logic                       cmd_nack_o,
  output logic                       bus_start_o,
  output logic                       bus_rstart_o,
  output logic                       bus_stop_o,
  output logic [`I3C_ADDR_W:0]       bus_addr_o,
  output logic                       bus_addr_valid_o
);

  i3c_bus_pkg::bus_state_t  bus;
  i3c_bus_pkg::phy_mode_e   phy_mode;
  logic [`I3C_TIMING_W-1:0] t_low;
  logic [`I3C_TIMING_W-1:0] t_high;
  logic [`I3C_ADDR_W-1:0]   target_addr;
  logic                     target_addr_valid;
  logic                     active_en;
  logic                     active_sel;

  i3c_phy_if active_phy ();
  i3c_phy_if target_phy ();

  bus_monitor u_bus_monitor (
    .clk_i,
    .arst_n_i,
    .scl_i,
    .sda_i,
    .state_o(bus)
  );

  configuration u_configuration (
    .clk_i,
    .arst_n_i,
    .cfg_we_i,
    .cfg_idx_i,
    .cfg_wdata_i,
    .phy_mode_o         (phy_mode),
    .t_low_o            (t_low),
    .t_high_o           (t_high),
    .target_addr_o      (target_addr),
    .target_addr_valid_o(target_addr_valid),
    .active_en_o        (active_en)
  );

  // Commands only while the controller owns the pins
  assign active_sel = active_en && (phy_mode == i3c_bus_pkg::mode_i2c_active);

  i2c_active_ctrl u_active_ctrl (
    .clk_i,
    .arst_n_i,
    .phy        (active_phy),
    .en_i       (active_sel),
    .t_low_i    (t_low),
    .t_high_i   (t_high),
    .cmd_valid_i,
    .cmd_addr_i,
    .cmd_rnw_i,
    .cmd_busy_o,
    .cmd_done_o,
    .cmd_nack_o
  );

  i2c_target_rx u_target_rx (
    .clk_i,
    .arst_n_i,
    .phy             (target_phy),
    .own_addr_i      (target_addr),
    .own_addr_valid_i(target_addr_valid),
    .addr_o          (bus_addr_o),
    .addr_valid_o    (bus_addr_valid_o)
  );

  always_comb begin : phy_select
    active_phy.state = i3c_bus_pkg::bus_idle_state;
    target_phy.state = i3c_bus_pkg::bus_idle_state;
    scl_o            = 1'b1;
    sda_o            = 1'b1;
    sel_od_pp_o      = 1'b0;
    case (phy_mode)
      i3c_bus_pkg::mode_i2c_active: begin
        active_phy.state = bus;
        scl_o            = active_phy.scl_drv;
        sda_o            = active_phy.sda_drv;
        sel_od_pp_o      = active_phy.sel_od_pp;
      end
      i3c_bus_pkg::mode_i2c_standby: begin
        target_phy.state = bus;
        scl_o            = target_phy.scl_drv;
        sda_o            = target_phy.sda_drv;
        sel_od_pp_o      = target_phy.sel_od_pp;
      end
      default: begin
      end
    endcase
  end

  assign bus_start_o  = bus.start_det;
  assign bus_rstart_o = bus.rstart_det;
  assign bus_stop_o   = bus.stop_det;

endmodule

// File: i2c_target_rx.sv
////////////////////////////////////////////////////////////////////////////
// I2C target for the address phase: shifts in one byte after each START
// Every byte is reported, ACK is given only on a valid static address match
// SCL is never driven, so the target cannot stretch the clock
////////////////////////////////////////////////////////////////////////////

`include "i3c_macros.svh"

module i2c_target_rx (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  i3c_phy_if.peer                phy,
  input  logic [`I3C_ADDR_W-1:0] own_addr_i,
  input  logic                   own_addr_valid_i,
  output logic [`I3C_ADDR_W:0]   addr_o,
  output logic                   addr_valid_o
);

  typedef enum logic [1:0] {
    st_idle,
    st_addr,
    st_ack_wait,
    st_ack
  } state_e;

  state_e                 state_q;
  logic [2:0]             bit_cnt_q;
  logic [`I3C_ADDR_W-1:0] shift_q;
  logic [`I3C_ADDR_W:0]   addr_q;
  logic                   valid_q;
  logic [`I3C_ADDR_W:0]   byte_in;
  logic                   match;
  logic                   last_bit;

  // Byte as it stands once the current SDA bit is taken in
  assign byte_in  = {shift_q, phy.state.sda.value};
  assign match    = own_addr_valid_i && (byte_in[`I3C_ADDR_W:1] == own_addr_i);
  assign last_bit = (state_q == st_addr) && phy.state.scl.pos_edge && (bit_cnt_q == 3'd7);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= st_idle;
      bit_cnt_q <= '0;
      addr_q    <= '0;
      valid_q   <= 1'b0;
    end else begin
      valid_q <= last_bit;
      if (last_bit) begin
        addr_q <= byte_in;
      end
      if (phy.state.start_det || phy.state.rstart_det) begin
        state_q   <= st_addr;
        bit_cnt_q <= '0;
      end else if (phy.state.stop_det) begin
        state_q <= st_idle;
      end else begin
        case (state_q)
          st_addr: begin
            if (phy.state.scl.pos_edge) begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
              if (bit_cnt_q == 3'd7) begin
                state_q <= match ? st_ack_wait : st_idle;
              end
            end
          end
          st_ack_wait: begin
            if (phy.state.scl.neg_edge) begin
              state_q <= st_ack;
            end
          end
          st_ack: begin
            if (phy.state.scl.neg_edge) begin
              state_q <= st_idle;
            end
          end
          default: begin
            state_q <= st_idle;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == st_addr && phy.state.scl.pos_edge) begin
      shift_q <= byte_in[`I3C_ADDR_W-1:0];
    end
  end

  assign phy.scl_drv   = 1'b1;
  assign phy.sda_drv   = (state_q != st_ack);
  assign phy.sel_od_pp = 1'b0;

  assign addr_o       = addr_q;
  assign addr_valid_o = valid_q;

endmodule

// File: i2c_active_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// I2C controller for the address phase only: START, address + RnW, ACK, STOP
// SDA is sampled at mid high of the ninth clock, a high reports NACK
// Open drain throughout, no arbitration loss detection
////////////////////////////////////////////////////////////////////////////

`include "i3c_macros.svh"

module i2c_active_ctrl (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  i3c_phy_if.peer                  phy,
  input  logic                     en_i,
  input  logic [`I3C_TIMING_W-1:0] t_low_i,
  input  logic [`I3C_TIMING_W-1:0] t_high_i,
  input  logic                     cmd_valid_i,
  input  logic [`I3C_ADDR_W-1:0]   cmd_addr_i,
  input  logic                     cmd_rnw_i,
  output logic                     cmd_busy_o,
  output logic                     cmd_done_o,
  output logic                     cmd_nack_o
);

  typedef enum logic [2:0] {
    st_idle,
    st_start,
    st_bit_low,
    st_bit_high,
    st_ack,
    st_stop
  } state_e;

  state_e                   state_q;
  logic [`I3C_TIMING_W-1:0] cnt_q;
  logic [3:0]               bit_cnt_q;
  logic [1:0]               stop_ph_q;
  logic [`I3C_ADDR_W:0]     shift_q;
  logic                     done_q;
  logic                     nack_q;
  logic                     cnt_zero;
  logic                     scl_high;
  logic                     accept;

  assign cnt_zero = (cnt_q == '0);
  assign scl_high = phy.state.scl.value;
  assign accept   = cmd_valid_i && en_i && (state_q == st_idle);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= st_idle;
      cnt_q     <= '0;
      bit_cnt_q <= '0;
      stop_ph_q <= '0;
      done_q    <= 1'b0;
      nack_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (!cnt_zero) begin
        cnt_q <= cnt_q - 1'b1;
      end
      case (state_q)
        st_idle: begin
          if (accept) begin
            state_q   <= st_start;
            cnt_q     <= t_high_i - 1'b1;
            bit_cnt_q <= '0;
          end
        end
        st_start: begin
          if (cnt_zero) begin
            state_q <= st_bit_low;
            cnt_q   <= t_low_i - 1'b1;
          end
        end
        st_bit_low: begin
          if (cnt_zero) begin
            state_q <= (bit_cnt_q == 4'd8) ? st_ack : st_bit_high;
            cnt_q   <= t_high_i - 1'b1;
          end
        end
        // High phase ends no earlier than the synchronized SCL high
        st_bit_high: begin
          if (cnt_zero && scl_high) begin
            state_q   <= st_bit_low;
            cnt_q     <= t_low_i - 1'b1;
            bit_cnt_q <= bit_cnt_q + 1'b1;
          end
        end
        st_ack: begin
          if (cnt_q == (t_high_i >> 1)) begin
            nack_q <= phy.state.sda.value;
          end
          if (cnt_zero && scl_high) begin
            state_q   <= st_stop;
            stop_ph_q <= '0;
            cnt_q     <= t_low_i - 1'b1;
          end
        end
        // Phases: SCL low, SCL high with SDA low, then bus free
        st_stop: begin
          if (cnt_zero) begin
            if (stop_ph_q == 2'd2) begin
              state_q <= st_idle;
              done_q  <= 1'b1;
            end else begin
              stop_ph_q <= stop_ph_q + 1'b1;
              cnt_q     <= t_high_i - 1'b1;
            end
          end
        end
        default: begin
          state_q <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      shift_q <= {cmd_addr_i, cmd_rnw_i};
    end else if (state_q == st_bit_high && cnt_zero && scl_high) begin
      shift_q <= {shift_q[`I3C_ADDR_W-1:0], 1'b0};
    end
  end

  always_comb begin
    phy.scl_drv   = 1'b1;
    phy.sda_drv   = 1'b1;
    phy.sel_od_pp = 1'b0;
    case (state_q)
      st_start: begin
        phy.sda_drv = 1'b0;
      end
      st_bit_low: begin
        phy.scl_drv = 1'b0;
        phy.sda_drv = (bit_cnt_q == 4'd8) ? 1'b1 : shift_q[`I3C_ADDR_W];
      end
      st_bit_high: begin
        phy.sda_drv = shift_q[`I3C_ADDR_W];
      end
      st_stop: begin
        phy.scl_drv = (stop_ph_q != 2'd0);
        phy.sda_drv = (stop_ph_q == 2'd2);
      end
      default: begin
      end
    endcase
  end

  assign cmd_busy_o = (state_q != st_idle);
  assign cmd_done_o = done_q;
  assign cmd_nack_o = nack_q;

endmodule

// File: configuration.sv
////////////////////////////////////////////////////////////////////////////
// Write-only settings registers, decoded per index through cfg_word_u
// A write is visible on the outputs the cycle after it is sampled
////////////////////////////////////////////////////////////////////////////

`include "i3c_macros.svh"

module configuration (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       cfg_we_i,
  input  logic [`I3C_CFG_IDX_W-1:0]  cfg_idx_i,
  input  logic [`I3C_CFG_DATA_W-1:0] cfg_wdata_i,
  output i3c_bus_pkg::phy_mode_e     phy_mode_o,
  output logic [`I3C_TIMING_W-1:0]   t_low_o,
  output logic [`I3C_TIMING_W-1:0]   t_high_o,
  output logic [`I3C_ADDR_W-1:0]     target_addr_o,
  output logic                       target_addr_valid_o,
  output logic                       active_en_o
);

  i3c_cfg_pkg::cfg_word_u wr_word;

  assign wr_word = cfg_wdata_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      phy_mode_o          <= i3c_bus_pkg::mode_i2c_active;
      t_low_o             <= `I3C_TIMING_W'(`I3C_T_LOW_RST);
      t_high_o            <= `I3C_TIMING_W'(`I3C_T_HIGH_RST);
      target_addr_o       <= '0;
      target_addr_valid_o <= 1'b0;
      active_en_o         <= 1'b0;
    end else if (cfg_we_i) begin
      case (i3c_cfg_pkg::cfg_idx_e'(cfg_idx_i))
        i3c_cfg_pkg::idx_ctrl: begin
          phy_mode_o          <= wr_word.ctrl.phy_mode;
          target_addr_o       <= wr_word.ctrl.static_addr;
          target_addr_valid_o <= wr_word.ctrl.static_addr_valid;
          active_en_o         <= wr_word.ctrl.active_en;
        end
        i3c_cfg_pkg::idx_t_low: begin
          t_low_o <= wr_word.timing.cycles;
        end
        i3c_cfg_pkg::idx_t_high: begin
          t_high_o <= wr_word.timing.cycles;
        end
        default: begin
        end
      endcase
    end
  end

endmodule

// File: bus_monitor.sv
////////////////////////////////////////////////////////////////////////////
// Two-flop synchronizer and START / repeated START / STOP detector
// Events come I3C_SYNC_STAGES + 1 cycles after the pins, with no filtering
////////////////////////////////////////////////////////////////////////////

`include "i3c_macros.svh"

module bus_monitor (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    scl_i,
  input  logic                    sda_i,
  output i3c_bus_pkg::bus_state_t state_o
);

  logic [`I3C_SYNC_STAGES-1:0] scl_sync_q;
  logic [`I3C_SYNC_STAGES-1:0] sda_sync_q;
  logic                        scl_s;
  logic                        sda_s;
  logic                        scl_hi;
  logic                        sda_fall;
  logic                        sda_rise;
  i3c_bus_pkg::bus_state_t     state_q;

  function automatic i3c_bus_pkg::bus_line_t line_next(i3c_bus_pkg::bus_line_t prev,
                                                       logic cur);
    i3c_bus_pkg::bus_line_t nxt;
    nxt.value       = cur;
    nxt.pos_edge    = cur & ~prev.value;
    nxt.neg_edge    = ~cur & prev.value;
    nxt.stable_high = cur & prev.value;
    return nxt;
  endfunction

  assign scl_s = scl_sync_q[`I3C_SYNC_STAGES-1];
  assign sda_s = sda_sync_q[`I3C_SYNC_STAGES-1];

  // SCL high over two samples while SDA moves
  assign scl_hi   = scl_s & state_q.scl.value;
  assign sda_fall = ~sda_s & state_q.sda.value;
  assign sda_rise = sda_s & ~state_q.sda.value;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      scl_sync_q <= '1;
      sda_sync_q <= '1;
      state_q    <= i3c_bus_pkg::bus_idle_state;
    end else begin
      scl_sync_q         <= {scl_sync_q[`I3C_SYNC_STAGES-2:0], scl_i};
      sda_sync_q         <= {sda_sync_q[`I3C_SYNC_STAGES-2:0], sda_i};
      state_q.scl        <= line_next(state_q.scl, scl_s);
      state_q.sda        <= line_next(state_q.sda, sda_s);
      state_q.start_det  <= scl_hi & sda_fall & ~state_q.busy;
      state_q.rstart_det <= scl_hi & sda_fall & state_q.busy;
      state_q.stop_det   <= scl_hi & sda_rise;
      if (scl_hi && sda_fall) begin
        state_q.busy <= 1'b1;
      end else if (scl_hi && sda_rise) begin
        state_q.busy <= 1'b0;
      end
    end
  end

  assign state_o = state_q;

endmodule

// File: i3c_phy_if.sv
////////////////////////////////////////////////////////////////////////////
// Link between the PHY select and one peer
// Pin drives are open drain, 1 releases the line
////////////////////////////////////////////////////////////////////////////

interface i3c_phy_if;

  i3c_bus_pkg::bus_state_t state;
  logic                    scl_drv;
  logic                    sda_drv;
  logic                    sel_od_pp;

  // Peer side sees the bus and drives the pins
  modport peer (
    input  state,
    output scl_drv,
    output sda_drv,
    output sel_od_pp
  );

  modport phy (
    output state,
    input  scl_drv,
    input  sda_drv,
    input  sel_od_pp
  );

endinterface

// File: i3c_cfg_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Configuration register index and the two views of a register word
// Index 3 is reserved and writes to it have no effect
////////////////////////////////////////////////////////////////////////////

`include "i3c_macros.svh"

package i3c_cfg_pkg;

  typedef enum logic [`I3C_CFG_IDX_W-1:0] {
    idx_ctrl   = 2'd0,
    idx_t_low  = 2'd1,
    idx_t_high = 2'd2,
    idx_rsvd   = 2'd3
  } cfg_idx_e;

  // CTRL: mode in bits 1:0, address in 8:2, valid in 9, enable in 10
  typedef struct packed {
    logic [`I3C_CFG_DATA_W-`I3C_ADDR_W-5:0] rsvd;
    logic                                    active_en;
    logic                                    static_addr_valid;
    logic [`I3C_ADDR_W-1:0]                  static_addr;
    i3c_bus_pkg::phy_mode_e                  phy_mode;
  } cfg_ctrl_t;

  // T_LOW and T_HIGH share this layout
  typedef struct packed {
    logic [`I3C_CFG_DATA_W-`I3C_TIMING_W-1:0] rsvd;
    logic [`I3C_TIMING_W-1:0]                 cycles;
  } cfg_timing_t;

  typedef union packed {
    cfg_ctrl_t   ctrl;
    cfg_timing_t timing;
  } cfg_word_u;

endpackage

// File: i3c_bus_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Bus state as seen by the peers, and the PHY mux codes
// Mux codes 1 and 3 (I3C) have no peer behind them
////////////////////////////////////////////////////////////////////////////

package i3c_bus_pkg;

  // One synchronized bus line
  typedef struct packed {
    logic value;
    logic pos_edge;
    logic neg_edge;
    logic stable_high;
  } bus_line_t;

  typedef struct packed {
    bus_line_t sda;
    bus_line_t scl;
    logic      start_det;
    logic      rstart_det;
    logic      stop_det;
    logic      busy;
  } bus_state_t;

  typedef enum logic [1:0] {
    mode_i2c_active  = 2'd0,
    mode_i3c_active  = 2'd1,
    mode_i2c_standby = 2'd2,
    mode_i3c_standby = 2'd3
  } phy_mode_e;

  // Both lines high and stable, no events
  parameter bus_line_t bus_line_idle = '{value: 1'b1, pos_edge: 1'b0,
                                         neg_edge: 1'b0, stable_high: 1'b1};
  parameter bus_state_t bus_idle_state = '{sda: bus_line_idle, scl: bus_line_idle,
                                           start_det: 1'b0, rstart_det: 1'b0,
                                           stop_det: 1'b0, busy: 1'b0};

endpackage

// File: i3c_macros.svh
////////////////////////////////////////////////////////////////////////////
// Widths and reset constants shared by the I2C front end
// Timing counts are in clk_i cycles and must be at least 1
////////////////////////////////////////////////////////////////////////////

`ifndef I3C_MACROS_SVH
`define I3C_MACROS_SVH

// Timing field and bus address widths
`define I3C_TIMING_W 20
`define I3C_ADDR_W 7

// Configuration port
`define I3C_CFG_DATA_W 32
`define I3C_CFG_IDX_W 2

// Input synchronizer depth
`define I3C_SYNC_STAGES 2

// Default SCL phases after reset
`define I3C_T_LOW_RST 50
`define I3C_T_HIGH_RST 50

`endif
